/* beam_reduce_pkg.sv */
//--------------------------------------------------------------------------
// widths, types and the fixed walsh sign codebook of the beam reduction path
// BEAM_W and BEAM_IDX_W follow the default antenna and beam counts
//--------------------------------------------------------------------------
package beam_reduce_pkg;

    localparam int ANT_N      = 8;
    localparam int BEAM_N     = 8;
    localparam int SAMPLE_W   = 16;
    localparam int BEAM_W     = SAMPLE_W + $clog2(ANT_N);  // 19, no overflow for 8 ants
    localparam int POWER_W    = BEAM_W + 1;                // |I|+|Q|
    localparam int RBG_LEN_W  = 6;                         // 1..63 REs, 0 acts as 1
    localparam int ACC_W      = POWER_W + RBG_LEN_W;
    localparam int BEAM_IDX_W = $clog2(BEAM_N);

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [BEAM_W-1:0]   beam_sum_t;
    typedef logic        [POWER_W-1:0]  power_t;
    typedef logic        [ACC_W-1:0]    acc_t;

    //----------------------------------------------------------------------
    // codebook, bit set means weight -1 (odd parity of beam & antenna)
    //----------------------------------------------------------------------
    function automatic logic [BEAM_N-1:0][ANT_N-1:0] gen_codebook();
        logic [BEAM_N-1:0][ANT_N-1:0] cb;
        cb = '0;
        for (int b = 0; b < BEAM_N; b++) begin
            for (int a = 0; a < ANT_N; a++) begin
                cb[b][a] = ^(a & b);
            end
        end
        return cb;
    endfunction

    localparam logic [BEAM_N-1:0][ANT_N-1:0] CODEBOOK = gen_codebook();

    // apb register map, byte addresses
    localparam logic [3:0] REG_CTRL    = 4'h0;
    localparam logic [3:0] REG_RBG_LEN = 4'h4;
    localparam logic [3:0] REG_RBG_CNT = 4'h8;

    localparam logic [RBG_LEN_W-1:0] RBG_LEN_RESET = 6'd12;

endpackage

/* beam_cfg_apb.sv */
//--------------------------------------------------------------------------
// apb slave, zero wait states, pready tied high
// rbg counter saturates at 16 bits and ignores writes
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module beam_cfg_apb import beam_reduce_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_psel,
    input  logic                 i_penable,
    input  logic                 i_pwrite,
    input  logic [3:0]           i_paddr,
    input  logic [31:0]          i_pwdata,
    output logic [31:0]          o_prdata,
    output logic                 o_pready,
    input  logic                 i_rbg_done,
    output logic                 o_enable,
    output logic [RBG_LEN_W-1:0] o_rbg_len
);

    localparam int CNT_W = 16;

    logic             wr_en;
    logic [CNT_W-1:0] rbg_cnt;

    assign o_pready = 1'b1;
    assign wr_en    = i_psel & i_penable & i_pwrite;  // access phase

    //----------------------------------------------------------------------
    // writable registers
    //----------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_enable  <= 1'b0;
            o_rbg_len <= RBG_LEN_RESET;
        end else if (wr_en) begin
            if (i_paddr == REG_CTRL) begin
                o_enable <= i_pwdata[0];
            end
            if (i_paddr == REG_RBG_LEN) begin
                o_rbg_len <= i_pwdata[RBG_LEN_W-1:0];
            end
        end
    end

    // completed rbg count, sticks at all ones
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            rbg_cnt <= '0;
        end else if (i_rbg_done && (rbg_cnt != '1)) begin
            rbg_cnt <= rbg_cnt + 1'b1;
        end
    end

    // read mux, unmapped reads return zero
    always_comb begin
        o_prdata = '0;
        case (i_paddr)
            REG_CTRL:    o_prdata[0]             = o_enable;
            REG_RBG_LEN: o_prdata[RBG_LEN_W-1:0] = o_rbg_len;
            REG_RBG_CNT: o_prdata[CNT_W-1:0]     = rbg_cnt;
            default:     o_prdata                = '0;
        endcase
    end

endmodule

/* beam_mac.sv */
//--------------------------------------------------------------------------
// sign-only beamformer, one RE per cycle, one cycle latency
// weights come from CODEBOOK, so ANT_N and BEAM_N must not exceed its size
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module beam_mac import beam_reduce_pkg::*; #(
    parameter int ANT_N  = beam_reduce_pkg::ANT_N,
    parameter int BEAM_N = beam_reduce_pkg::BEAM_N
) (
    input  logic      i_clk,
    input  logic      i_reset,
    input  sample_t   i_ant_i [ANT_N],
    input  sample_t   i_ant_q [ANT_N],
    input  logic      i_vld,
    output beam_sum_t o_beam_i [BEAM_N],
    output beam_sum_t o_beam_q [BEAM_N],
    output logic      o_vld
);

    beam_sum_t sum_i [BEAM_N];
    beam_sum_t sum_q [BEAM_N];

    //----------------------------------------------------------------------
    // add or subtract every antenna per beam
    //----------------------------------------------------------------------
    always_comb begin
        for (int b = 0; b < BEAM_N; b++) begin
            sum_i[b] = '0;
            sum_q[b] = '0;
            for (int a = 0; a < ANT_N; a++) begin
                if (CODEBOOK[b][a]) begin
                    sum_i[b] = sum_i[b] - beam_sum_t'(i_ant_i[a]);
                    sum_q[b] = sum_q[b] - beam_sum_t'(i_ant_q[a]);
                end else begin
                    sum_i[b] = sum_i[b] + beam_sum_t'(i_ant_i[a]);
                    sum_q[b] = sum_q[b] + beam_sum_t'(i_ant_q[a]);
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        for (int b = 0; b < BEAM_N; b++) begin
            o_beam_i[b] <= sum_i[b];
            o_beam_q[b] <= sum_q[b];
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_vld <= 1'b0;
        end else begin
            o_vld <= i_vld;
        end
    end

endmodule

/* beam_power.sv */
//--------------------------------------------------------------------------
// |I|+|Q| magnitude estimate, two register stages
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module beam_power import beam_reduce_pkg::*; #(
    parameter int BEAM_N = beam_reduce_pkg::BEAM_N
) (
    input  logic      i_clk,
    input  logic      i_reset,
    input  beam_sum_t i_beam_i [BEAM_N],
    input  beam_sum_t i_beam_q [BEAM_N],
    input  logic      i_vld,
    output power_t    o_power [BEAM_N],
    output logic      o_vld
);

    logic [BEAM_W-1:0] abs_i [BEAM_N];  // unsigned, most negative input still fits
    logic [BEAM_W-1:0] abs_q [BEAM_N];
    logic              vld_d1;

    always_ff @(posedge i_clk) begin
        for (int b = 0; b < BEAM_N; b++) begin
            abs_i[b]   <= (i_beam_i[b] < 0) ? -i_beam_i[b] : i_beam_i[b];
            abs_q[b]   <= (i_beam_q[b] < 0) ? -i_beam_q[b] : i_beam_q[b];
            o_power[b] <= power_t'(abs_i[b]) + power_t'(abs_q[b]);
        end
    end

    // valid follows both stages
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            vld_d1 <= 1'b0;
            o_vld  <= 1'b0;
        end else begin
            vld_d1 <= i_vld;
            o_vld  <= vld_d1;
        end
    end

endmodule

/* rbg_accum.sv */
//--------------------------------------------------------------------------
// per-beam power sum over one RBG, length latched at the first RE
// clearing the enable drops the partial RBG, a length of 0 counts as 1
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module rbg_accum import beam_reduce_pkg::*; #(
    parameter int BEAM_N = beam_reduce_pkg::BEAM_N
) (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  power_t               i_power [BEAM_N],
    input  logic                 i_vld,
    input  logic                 i_enable,
    input  logic [RBG_LEN_W-1:0] i_rbg_len,
    output acc_t                 o_sum [BEAM_N],
    output logic                 o_sum_vld
);

    logic [RBG_LEN_W-1:0] re_cnt;
    logic [RBG_LEN_W-1:0] len_lat;
    logic [RBG_LEN_W-1:0] new_len;
    logic [RBG_LEN_W-1:0] cur_len;
    logic                 active;
    logic                 first_re;
    logic                 last_re;
    acc_t                 run_sum [BEAM_N];

    assign active   = i_vld & i_enable;
    assign first_re = (re_cnt == '0);
    assign new_len  = (i_rbg_len == '0) ? RBG_LEN_W'(1) : i_rbg_len;
    assign cur_len  = first_re ? new_len : len_lat;
    assign last_re  = active & (re_cnt == cur_len - 1'b1);

    //----------------------------------------------------------------------
    // RE counter
    //----------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset || !i_enable) begin
            re_cnt    <= '0;
            len_lat   <= RBG_LEN_RESET;
            o_sum_vld <= 1'b0;
        end else begin
            o_sum_vld <= last_re;
            if (active) begin
                re_cnt <= last_re ? '0 : re_cnt + 1'b1;
                if (first_re) begin
                    len_lat <= new_len;
                end
            end
        end
    end

    // running sums, first RE loads
    always_ff @(posedge i_clk) begin
        for (int b = 0; b < BEAM_N; b++) begin
            if (active) begin
                run_sum[b] <= first_re ? acc_t'(i_power[b]) : run_sum[b] + acc_t'(i_power[b]);
            end
            if (last_re) begin
                o_sum[b] <= first_re ? acc_t'(i_power[b]) : run_sum[b] + acc_t'(i_power[b]);
            end
        end
    end

endmodule

/* beam_rank.sv */
//--------------------------------------------------------------------------
// picks the two strongest beams of a sum vector, ties go to the lower index
// needs BEAM_N of at least 2
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module beam_rank import beam_reduce_pkg::*; #(
    parameter int BEAM_N = beam_reduce_pkg::BEAM_N
) (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  acc_t                  i_sum [BEAM_N],
    input  logic                  i_vld,
    output logic                  o_vld,
    output logic [BEAM_IDX_W-1:0] o_top_idx,
    output acc_t                  o_top_pwr,
    output logic [BEAM_IDX_W-1:0] o_second_idx,
    output acc_t                  o_second_pwr
);

    logic [BEAM_IDX_W-1:0] top_idx;
    logic [BEAM_IDX_W-1:0] sec_idx;
    acc_t                  top_pwr;
    acc_t                  sec_pwr;

    //----------------------------------------------------------------------
    // linear scan, strict compare keeps the earlier beam on ties
    //----------------------------------------------------------------------
    always_comb begin
        if (i_sum[1] > i_sum[0]) begin
            top_idx = BEAM_IDX_W'(1);
            top_pwr = i_sum[1];
            sec_idx = '0;
            sec_pwr = i_sum[0];
        end else begin
            top_idx = '0;
            top_pwr = i_sum[0];
            sec_idx = BEAM_IDX_W'(1);
            sec_pwr = i_sum[1];
        end
        for (int b = 2; b < BEAM_N; b++) begin
            if (i_sum[b] > top_pwr) begin
                sec_idx = top_idx;  // old top drops to second
                sec_pwr = top_pwr;
                top_idx = BEAM_IDX_W'(b);
                top_pwr = i_sum[b];
            end else if (i_sum[b] > sec_pwr) begin
                sec_idx = BEAM_IDX_W'(b);
                sec_pwr = i_sum[b];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_vld) begin
            o_top_idx    <= top_idx;
            o_top_pwr    <= top_pwr;
            o_second_idx <= sec_idx;
            o_second_pwr <= sec_pwr;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_vld <= 1'b0;
        end else begin
            o_vld <= i_vld;
        end
    end

endmodule

/* beam_reduce_top.sv */
//--------------------------------------------------------------------------
// beam reduction top, no back-pressure, one RE per cycle
// o_rank_vld comes 5 cycles after the last RE of an RBG
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module beam_reduce_top import beam_reduce_pkg::*; (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_psel,
    input  logic                  i_penable,
    input  logic                  i_pwrite,
    input  logic [3:0]            i_paddr,
    input  logic [31:0]           i_pwdata,
    output logic [31:0]           o_prdata,
    output logic                  o_pready,
    input  sample_t               i_ant_i [ANT_N],
    input  sample_t               i_ant_q [ANT_N],
    input  logic                  i_re_vld,
    output logic                  o_rank_vld,
    output logic [BEAM_IDX_W-1:0] o_top_idx,
    output acc_t                  o_top_pwr,
    output logic [BEAM_IDX_W-1:0] o_second_idx,
    output acc_t                  o_second_pwr
);

    logic                 enable;
    logic [RBG_LEN_W-1:0] rbg_len;
    beam_sum_t            beam_i [BEAM_N];
    beam_sum_t            beam_q [BEAM_N];
    logic                 mac_vld;
    power_t               power [BEAM_N];
    logic                 pwr_vld;
    acc_t                 rbg_sum [BEAM_N];
    logic                 sum_vld;

    //----------------------------------------------------------------------
    // configuration, counts finished RBGs from the rank valid
    //----------------------------------------------------------------------
    beam_cfg_apb u_cfg (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_psel     (i_psel),
        .i_penable  (i_penable),
        .i_pwrite   (i_pwrite),
        .i_paddr    (i_paddr),
        .i_pwdata   (i_pwdata),
        .o_prdata   (o_prdata),
        .o_pready   (o_pready),
        .i_rbg_done (o_rank_vld),
        .o_enable   (enable),
        .o_rbg_len  (rbg_len)
    );

    //----------------------------------------------------------------------
    // data pipeline  mac(1) -> power(2) -> accum(1) -> rank(1)
    //----------------------------------------------------------------------
    beam_mac #(.ANT_N(ANT_N), .BEAM_N(BEAM_N)) u_mac (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_ant_i  (i_ant_i),
        .i_ant_q  (i_ant_q),
        .i_vld    (i_re_vld),
        .o_beam_i (beam_i),
        .o_beam_q (beam_q),
        .o_vld    (mac_vld)
    );

    beam_power #(.BEAM_N(BEAM_N)) u_power (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_beam_i (beam_i),
        .i_beam_q (beam_q),
        .i_vld    (mac_vld),
        .o_power  (power),
        .o_vld    (pwr_vld)
    );

    rbg_accum #(.BEAM_N(BEAM_N)) u_accum (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_power   (power),
        .i_vld     (pwr_vld),
        .i_enable  (enable),
        .i_rbg_len (rbg_len),
        .o_sum     (rbg_sum),
        .o_sum_vld (sum_vld)
    );

    beam_rank #(.BEAM_N(BEAM_N)) u_rank (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_sum        (rbg_sum),
        .i_vld        (sum_vld),
        .o_vld        (o_rank_vld),
        .o_top_idx    (o_top_idx),
        .o_top_pwr    (o_top_pwr),
        .o_second_idx (o_second_idx),
        .o_second_pwr (o_second_pwr)
    );

endmodule

/* tb_beam_reduce_assertions.sv */
//--------------------------------------------------------------------------
// bound into beam_reduce_top, apb ready and rank output sanity
// back-to-back rank pulses are legal only at an RBG length of 0 or 1
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_beam_reduce_assertions import beam_reduce_pkg::*; (
    input logic                  i_clk,
    input logic                  i_reset,
    input logic                  i_pready,
    input logic                  i_rank_vld,
    input logic [RBG_LEN_W-1:0]  i_rbg_len,
    input logic [BEAM_IDX_W-1:0] i_top_idx,
    input logic [BEAM_IDX_W-1:0] i_second_idx,
    input acc_t                  i_top_pwr,
    input acc_t                  i_second_pwr
);

    // zero wait states on every access
    a_pready: assert property (@(posedge i_clk) disable iff (i_reset) i_pready)
        else $error("o_pready went low");

    a_rank_gap: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_rank_vld && $past(i_rank_vld)) |-> (i_rbg_len <= 1))
        else $error("o_rank_vld high two cycles in a row with RBG length %0d", i_rbg_len);

    // top and second must be distinct and ordered
    a_rank_order: assert property (@(posedge i_clk) disable iff (i_reset)
        i_rank_vld |-> ((i_top_idx != i_second_idx) && (i_top_pwr >= i_second_pwr)))
        else $error("rank output inconsistent, top %0d second %0d", i_top_idx, i_second_idx);

endmodule

/* tb_beam_reduce.sv */
//--------------------------------------------------------------------------
// testbench for the beam reduction path, model built on the walsh sign rule
// all tests run from one reset, RBG length only changes while idle
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_beam_reduce import beam_reduce_pkg::*; ();

    localparam int MAX_CYCLES = 3000;  // generous bound, full run needs far less
    localparam int AMP        = 1000;

    logic                  clk;
    logic                  reset;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [3:0]            paddr;
    logic [31:0]           pwdata;
    logic [31:0]           prdata;
    logic                  pready;
    sample_t               ant_i [ANT_N];
    sample_t               ant_q [ANT_N];
    logic                  re_vld;
    logic                  rank_vld;
    logic [BEAM_IDX_W-1:0] top_idx;
    logic [BEAM_IDX_W-1:0] second_idx;
    acc_t                  top_pwr;
    acc_t                  second_pwr;

    int          cycle = 0;
    int          err_cnt = 0;
    int          chk_cnt = 0;
    int          timing_err = 0;
    int          rank_seen = 0;
    int          rbg_exp = 0;
    int          seen_before;
    int          test_num = 0;
    int          test_err = 0;
    int          last_top = 0;
    int          cur_i [ANT_N];
    int          cur_q [ANT_N];
    longint      acc [BEAM_N];
    bit          model_en = 1'b0;
    int          model_len = 4;
    int          re_in_rbg = 0;
    int          q_due [$];
    int          q_top_idx [$];
    longint      q_top_pwr [$];
    int          q_sec_idx [$];
    longint      q_sec_pwr [$];
    logic [31:0] rd;

    beam_reduce_top i_beam_reduce_top (
        .i_clk        (clk),
        .i_reset      (reset),
        .i_psel       (psel),
        .i_penable    (penable),
        .i_pwrite     (pwrite),
        .i_paddr      (paddr),
        .i_pwdata     (pwdata),
        .o_prdata     (prdata),
        .o_pready     (pready),
        .i_ant_i      (ant_i),
        .i_ant_q      (ant_q),
        .i_re_vld     (re_vld),
        .o_rank_vld   (rank_vld),
        .o_top_idx    (top_idx),
        .o_top_pwr    (top_pwr),
        .o_second_idx (second_idx),
        .o_second_pwr (second_pwr)
    );

    bind beam_reduce_top tb_beam_reduce_assertions u_assertions (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_pready     (o_pready),
        .i_rank_vld   (o_rank_vld),
        .i_rbg_len    (rbg_len),
        .i_top_idx    (o_top_idx),
        .i_second_idx (o_second_idx),
        .i_top_pwr    (o_top_pwr),
        .i_second_pwr (o_second_pwr)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("timeout, run stopped after %0d cycles", cycle);
            $display("test failed");
            $finish;
        end
    end

    //----------------------------------------------------------------------
    // helpers
    //----------------------------------------------------------------------
    task automatic check_value(input string name, input longint got, input longint exp);
        chk_cnt++;
        assert (got == exp) else begin
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
        @(negedge clk);
        psel   = 1'b1;
        pwrite = 1'b1;
        paddr  = addr;
        pwdata = data;
        @(negedge clk);
        penable = 1'b1;  // lands at the next rising edge
        while (!pready) begin
            @(negedge clk);
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
        @(negedge clk);
        psel   = 1'b1;
        pwrite = 1'b0;
        paddr  = addr;
        @(negedge clk);
        penable = 1'b1;
        while (!pready) begin
            @(negedge clk);
        end
        data = prdata;  // stable through the access phase
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // beam b weight is -1 on odd parity of antenna & beam
    function automatic longint re_power(input int b);
        int si;
        int sq;
        si = 0;
        sq = 0;
        for (int a = 0; a < ANT_N; a++) begin
            si = (^(a & b)) ? si - cur_i[a] : si + cur_i[a];
            sq = (^(a & b)) ? sq - cur_q[a] : sq + cur_q[a];
        end
        return longint'((si < 0) ? -si : si) + longint'((sq < 0) ? -sq : sq);
    endfunction

    task automatic push_expected(input int due);
        int ti;
        int si;
        ti = 0;
        for (int b = 1; b < BEAM_N; b++) begin
            if (acc[b] > acc[ti]) begin
                ti = b;
            end
        end
        si = (ti == 0) ? 1 : 0;  // lowest index other than top
        for (int b = 0; b < BEAM_N; b++) begin
            if (b != ti && acc[b] > acc[si]) begin
                si = b;
            end
        end
        rbg_exp++;
        q_due.push_back(due);
        q_top_idx.push_back(ti);
        q_top_pwr.push_back(acc[ti]);
        q_sec_idx.push_back(si);
        q_sec_pwr.push_back(acc[si]);
    endtask

    task automatic fill_row(input int b, input int amp);
        for (int a = 0; a < ANT_N; a++) begin
            cur_i[a] = (^(a & b)) ? -amp : amp;
            cur_q[a] = (^(a & b)) ? -amp / 2 : amp / 2;
        end
    endtask

    task automatic fill_random();
        for (int a = 0; a < ANT_N; a++) begin
            cur_i[a] = $signed(16'($urandom));
            cur_q[a] = $signed(16'($urandom));
        end
    endtask

    task automatic send_re();
        @(negedge clk);
        for (int a = 0; a < ANT_N; a++) begin
            ant_i[a] = sample_t'(cur_i[a]);
            ant_q[a] = sample_t'(cur_q[a]);
        end
        re_vld = 1'b1;
        if (model_en) begin
            for (int b = 0; b < BEAM_N; b++) begin
                acc[b] = (re_in_rbg == 0) ? re_power(b) : acc[b] + re_power(b);
            end
            re_in_rbg++;
            if (re_in_rbg == model_len) begin
                push_expected(cycle + 5);  // mac 1, power 2, accum 1, rank 1
                re_in_rbg = 0;
            end
        end
    endtask

    task automatic wait_idle(input int n);
        repeat (n) begin
            @(negedge clk);
            re_vld = 1'b0;
        end
    endtask

    task automatic report_test(input string name, input bit ok);
        test_num++;
        $display("test %0d %s: %s", test_num, name, ok ? "ok" : "FAIL");
        test_err = err_cnt;
    endtask

    //----------------------------------------------------------------------
    // rank monitor, outputs sampled on the falling edge
    //----------------------------------------------------------------------
    task automatic check_rank();
        int due;
        rank_seen++;
        last_top = int'(top_idx);
        assert (q_due.size() != 0) else begin
            $display("o_rank_vld pulsed at cycle %0d with no RBG pending", cycle);
            err_cnt++;
            timing_err++;
        end
        if (q_due.size() != 0) begin
            due = q_due.pop_front();
            assert (cycle == due) else begin
                $display("o_rank_vld pulsed at cycle %0d, expected at cycle %0d", cycle, due);
                err_cnt++;
                timing_err++;
            end
            check_value("o_top_idx", top_idx, q_top_idx.pop_front());
            check_value("o_top_pwr", top_pwr, q_top_pwr.pop_front());
            check_value("o_second_idx", second_idx, q_sec_idx.pop_front());
            check_value("o_second_pwr", second_pwr, q_sec_pwr.pop_front());
        end
    endtask

    always @(negedge clk) begin
        if (!reset && rank_vld) begin
            check_rank();
        end
    end

    //----------------------------------------------------------------------
    // stimulus
    //----------------------------------------------------------------------
    initial begin
        void'($urandom(32'hd2cca0bf));
        clk     = 1'b0;
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        re_vld  = 1'b0;
        for (int a = 0; a < ANT_N; a++) begin
            ant_i[a] = '0;
            ant_q[a] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // register reset values and writes
        read_reg(REG_CTRL, rd);
        check_value("o_prdata REG_CTRL", rd, 0);
        read_reg(REG_RBG_LEN, rd);
        check_value("o_prdata REG_RBG_LEN", rd, 12);
        read_reg(REG_RBG_CNT, rd);
        check_value("o_prdata REG_RBG_CNT", rd, 0);
        write_reg(REG_RBG_LEN, 32'd4);
        read_reg(REG_RBG_LEN, rd);
        check_value("o_prdata REG_RBG_LEN", rd, 4);
        write_reg(REG_RBG_CNT, 32'h5);
        read_reg(REG_RBG_CNT, rd);
        check_value("o_prdata REG_RBG_CNT", rd, 0);
        read_reg(4'hc, rd);  // unmapped
        check_value("o_prdata unmapped", rd, 0);
        report_test("register access", err_cnt == test_err);

        // samples follow the sign row of beam 5
        write_reg(REG_CTRL, 32'd1);
        model_en  = 1'b1;
        model_len = 4;
        fill_row(5, AMP);
        repeat (4) send_re();
        wait_idle(10);
        check_value("o_top_idx", last_top, 5);
        report_test("beam 5 pattern", err_cnt == test_err);

        // random RBGs, every eighth one all zero to force ties
        for (int r = 0; r < 40; r++) begin
            repeat (4) begin
                if (r % 8 == 3) begin
                    fill_row(0, 0);
                end else begin
                    fill_random();
                end
                send_re();
            end
            wait_idle($urandom_range(0, 2));
        end
        wait_idle(10);
        report_test("random RBGs", err_cnt == test_err);
        report_test("rank valid timing", timing_err == 0);

        // disabled, nothing may come out
        write_reg(REG_CTRL, 32'd0);
        model_en    = 1'b0;
        re_in_rbg   = 0;
        seen_before = rank_seen;
        repeat (8) begin
            fill_random();
            send_re();
        end
        wait_idle(10);
        check_value("o_rank_vld pulses while disabled", rank_seen - seen_before, 0);
        read_reg(REG_RBG_CNT, rd);
        check_value("o_prdata REG_RBG_CNT", rd, rbg_exp);
        report_test("enable cleared", err_cnt == test_err);

        // length 1, one result per RE
        write_reg(REG_RBG_LEN, 32'd1);
        write_reg(REG_CTRL, 32'd1);
        model_len   = 1;
        model_en    = 1'b1;
        seen_before = rank_seen;
        repeat (16) begin
            fill_random();
            send_re();
        end
        wait_idle(10);
        check_value("o_rank_vld pulses at length 1", rank_seen - seen_before, 16);
        read_reg(REG_RBG_CNT, rd);
        check_value("o_prdata REG_RBG_CNT", rd, rbg_exp);
        report_test("length 1", err_cnt == test_err);

        assert (q_due.size() == 0) else begin
            $display("%0d expected results never arrived", q_due.size());
            err_cnt++;
        end
        $display("%0d checks, %0d errors, %0d results", chk_cnt, err_cnt, rank_seen);
        if (err_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* beam_reduce_top.f */
beam_reduce_pkg.sv
beam_cfg_apb.sv
beam_mac.sv
beam_power.sv
rbg_accum.sv
beam_rank.sv
beam_reduce_top.sv
tb_beam_reduce_assertions.sv
tb_beam_reduce.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_beam_reduce \
		-f beam_reduce_top.f -o sim_beam_reduce
	./obj_dir/sim_beam_reduce | tee sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
